// File: verilog/schedPkg.sv
package schedPkg;
	localparam int TASK_WORD_W = 48;
	localparam int TASK_DEPTH = 64;
	localparam int TASK_AW = $clog2(TASK_DEPTH);

	// Control frame fields
	localparam int ACT_LO = 0;
	localparam int R0M_LO = 4;
	localparam int MASK_W = 4;
	localparam int FENCE_LO = 8;
	localparam int FENCE_W = 2;
	localparam int FCNT_LO = 10;
	localparam int FCNT_W = 4;
	localparam int INIT_LO = 14;			// Core 0 lowest byte
	localparam int INIT_W = 8;

	// Instruction frame fields
	localparam int OPC_LO = 0;
	localparam int OPC_W = 3;
	localparam int IMM_LO = 3;

	localparam int APB_AW = 12;
	localparam int APB_DW = 32;
	localparam logic [APB_AW-1:0] ADDR_CONTROL = 12'h200;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 12'h204;
	localparam logic [APB_AW-1:0] ADDR_R0_BASE = 12'h210;
	localparam int COUNT_W = 8;

	typedef enum logic [FENCE_W-1:0] {
		FENCE_NONE = 2'd0,
		FENCE_ACQ = 2'd1,
		FENCE_REL = 2'd2
	} fenceT;

	typedef enum logic [2:0] {
		IDLE, FETCH_CTRL, DECODE_CTRL, FETCH_INSN, ISSUE, DRAIN, HALT
	} schedStateT;
endpackage

// File: verilog/corePkg.sv
package corePkg;
	localparam int NUM_CORES = 4;
	localparam int REG_W = 16;
	localparam int IMM_W = 8;
	localparam int MUL_CYCLES = 4;
	localparam int MUL_CNT_W = $clog2(MUL_CYCLES);

	// Immediates are zero-extended to REG_W
	typedef enum logic [2:0] {
		OP_NOP = 3'd0,
		OP_ADDI = 3'd1,
		OP_SUBI = 3'd2,
		OP_XORI = 3'd3,
		OP_SHLI = 3'd4,			// Shift by imm[3:0]
		OP_MULI = 3'd5,
		OP_ADDC = 3'd6			// Peer core in imm[1:0]
	} opcodeT;
endpackage

// File: verilog/apbTaskLoader.sv
`timescale 1ns/10ps

module apbTaskLoader
	import schedPkg::*;
	import corePkg::*;
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [APB_AW-1:0] paddr,
	input logic [APB_DW-1:0] pwdata,
	input logic [TASK_AW-1:0] taskAddr,
	input logic busy,
	input logic done,
	input logic taskDone,
	input logic [NUM_CORES*REG_W-1:0] peerR0,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic go,
	output logic [TASK_WORD_W-1:0] taskWord
);
	logic [TASK_WORD_W-1:0] taskMem [TASK_DEPTH];
	logic [APB_DW-1:0] lowStage;
	logic [COUNT_W-1:0] taskCount;
	logic rdWait;
	logic access;
	logic isMem;
	logic isCtrl;
	logic isStatus;
	logic isR0;
	logic slowRead;
	logic addrErr;
	logic wrOk;
	logic [APB_DW-1:0] rdValue;

	assign access = psel && penable;
	assign isMem = paddr < ADDR_CONTROL;
	assign isCtrl = paddr == ADDR_CONTROL;
	assign isStatus = paddr == ADDR_STATUS;
	assign isR0 = paddr[APB_AW-1:4] == ADDR_R0_BASE[APB_AW-1:4] && paddr[1:0] == 2'b00;
	assign slowRead = !pwrite && (isStatus || isR0);

	// Memory and CONTROL only writable while idle; only STATUS and R0 readable
	assign addrErr = pwrite ? ((isMem || isCtrl) ? busy : 1'b1) : !slowRead;
	assign pready = !(access && slowRead && !rdWait);
	assign pslverr = access && pready && addrErr;
	assign wrOk = access && pwrite && !addrErr;

	always_ff @(posedge clk) begin
		if (wrOk && isMem && !paddr[2])
			lowStage <= pwdata;				// Staged low half
		if (wrOk && isMem && paddr[2])
			taskMem[paddr[TASK_AW+2:3]] <= {pwdata[TASK_WORD_W-APB_DW-1:0], lowStage};
		taskWord <= taskMem[taskAddr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			go <= 1'b0;
			taskCount <= '0;
			rdWait <= 1'b0;
		end else begin
			go <= wrOk && isCtrl && pwdata[0];
			if (go)
				taskCount <= '0;
			else if (taskDone)
				taskCount <= taskCount + 1'b1;
			rdWait <= access && slowRead && !rdWait;	// One wait state
		end
	end

	always_comb begin
		if (isStatus)
			rdValue = APB_DW'({taskCount, 6'b0, done, busy});
		else
			rdValue = APB_DW'(peerR0[paddr[3:2]*REG_W +: REG_W]);
	end

	always_ff @(posedge clk) begin
		if (access && slowRead && !rdWait)
			prdata <= rdValue;
	end

	assert property (@(posedge clk) disable iff (reset) penable |-> psel)
		else $error("APB penable without psel");
endmodule

// File: verilog/taskScheduler.sv
`timescale 1ns/10ps

module taskScheduler
	import schedPkg::*;
	import corePkg::*;
(
	input logic clk,
	input logic reset,
	input logic go,
	input logic [TASK_WORD_W-1:0] taskWord,
	input logic [NUM_CORES-1:0] ready,
	output logic [TASK_AW-1:0] taskAddr,
	output logic [NUM_CORES-1:0] start,
	output opcodeT insnOp,
	output logic [IMM_W-1:0] insnImm,
	output logic [NUM_CORES-1:0] initR0,
	output logic [NUM_CORES*IMM_W-1:0] initValue,
	output logic busy,
	output logic done,
	output logic taskDone
);
	schedStateT state;
	logic [TASK_AW-1:0] taskPtr;
	logic [FCNT_W-1:0] framesLeft;
	logic [NUM_CORES-1:0] activeMask;
	logic pendingRel;				// Last task was REL
	logic [MASK_W-1:0] ctrlActive;
	logic [MASK_W-1:0] ctrlR0Mask;
	fenceT ctrlFence;
	logic [FCNT_W-1:0] ctrlFrames;
	logic allReady;
	logic fenceOk;
	logic accept;
	logic issue;

	assign allReady = &ready;
	assign fenceOk = (ctrlFence == FENCE_ACQ || pendingRel) ? allReady
		: ((ctrlActive | ctrlR0Mask) & ~ready) == '0;
	assign accept = state == DRAIN && ctrlActive != '0 && fenceOk;
	assign issue = state == ISSUE && (activeMask & ~ready) == '0;

	// Next frame fetched while the current one issues
	assign taskAddr = issue ? taskPtr + 1'b1 : taskPtr;
	assign start = issue ? activeMask : '0;
	assign insnOp = opcodeT'(taskWord[OPC_LO +: OPC_W]);
	assign insnImm = taskWord[IMM_LO +: IMM_W];
	assign initR0 = accept ? ctrlR0Mask : '0;
	assign taskDone = (issue && framesLeft == 1) || (accept && ctrlFrames == '0);

	always_ff @(posedge clk) begin
		if (state == DECODE_CTRL) begin
			ctrlActive <= taskWord[ACT_LO +: MASK_W];
			ctrlR0Mask <= taskWord[R0M_LO +: MASK_W];
			ctrlFence <= fenceT'(taskWord[FENCE_LO +: FENCE_W]);
			ctrlFrames <= taskWord[FCNT_LO +: FCNT_W];
			initValue <= taskWord[INIT_LO +: NUM_CORES*INIT_W];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			taskPtr <= '0;
			framesLeft <= '0;
			activeMask <= '0;
			pendingRel <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			case (state)
				IDLE, HALT: begin
					if (go) begin
						state <= FETCH_CTRL;
						taskPtr <= '0;
						pendingRel <= 1'b0;
						busy <= 1'b1;
						done <= 1'b0;
					end
				end
				FETCH_CTRL: state <= DECODE_CTRL;
				DECODE_CTRL: state <= DRAIN;
				DRAIN: begin
					if (ctrlActive == '0) begin		// End of program
						if (allReady) begin
							state <= HALT;
							busy <= 1'b0;
							done <= 1'b1;
						end
					end else if (accept) begin
						activeMask <= ctrlActive;
						pendingRel <= ctrlFence == FENCE_REL;
						framesLeft <= ctrlFrames;
						taskPtr <= taskPtr + 1'b1;
						state <= (ctrlFrames == '0) ? FETCH_CTRL : FETCH_INSN;
					end
				end
				FETCH_INSN: state <= ISSUE;
				ISSUE: begin
					if (issue) begin
						taskPtr <= taskPtr + 1'b1;
						framesLeft <= framesLeft - 1'b1;
						if (framesLeft == 1)
							state <= FETCH_CTRL;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end
endmodule

// File: verilog/arrayCore.sv
`timescale 1ns/10ps

module arrayCore
	import corePkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input opcodeT insnOp,
	input logic [IMM_W-1:0] insnImm,
	input logic initR0,
	input logic [IMM_W-1:0] initValue,
	input logic [NUM_CORES*REG_W-1:0] peerR0,
	output logic [REG_W-1:0] r0,
	output logic ready
);
	logic [MUL_CNT_W-1:0] mulCount;
	logic [REG_W-1:0] mulResult;
	logic [REG_W-1:0] imm;
	logic [REG_W-1:0] peer;
	logic [REG_W-1:0] aluResult;

	assign imm = REG_W'(insnImm);
	assign peer = peerR0[insnImm[1:0]*REG_W +: REG_W];

	always_comb begin
		case (insnOp)
			OP_ADDI: aluResult = r0 + imm;
			OP_SUBI: aluResult = r0 - imm;
			OP_XORI: aluResult = r0 ^ imm;
			OP_SHLI: aluResult = r0 << insnImm[3:0];
			OP_ADDC: aluResult = r0 + peer;
			default: aluResult = r0;			// NOP, MULI handled below
		endcase
	end

	always_ff @(posedge clk) begin
		if (start && insnOp == OP_MULI)
			mulResult <= REG_W'(r0 * imm);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
			ready <= 1'b1;
			mulCount <= '0;
		end else if (initR0) begin
			r0 <= REG_W'(initValue);
		end else if (start && insnOp == OP_MULI) begin
			ready <= 1'b0;
			mulCount <= MUL_CNT_W'(MUL_CYCLES - 2);
		end else if (start) begin
			r0 <= aluResult;
		end else if (!ready) begin
			if (mulCount == '0) begin
				ready <= 1'b1;				// Result lands with ready
				r0 <= mulResult;
			end else begin
				mulCount <= mulCount - 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) start |-> ready)
		else $error("start while core busy");
	assert property (@(posedge clk) disable iff (reset) $fell(ready) |-> ##(MUL_CYCLES-1) ready)
		else $error("multiply latency wrong");
endmodule

// File: verilog/taskArray.sv
`timescale 1ns/10ps

module taskArray
	import schedPkg::*;
	import corePkg::*;
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [APB_AW-1:0] paddr,
	input logic [APB_DW-1:0] pwdata,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic doneIrq
);
	logic go;
	logic busy;
	logic taskDone;
	logic [TASK_AW-1:0] taskAddr;
	logic [TASK_WORD_W-1:0] taskWord;
	logic [NUM_CORES-1:0] start;
	logic [NUM_CORES-1:0] initR0;
	logic [NUM_CORES-1:0] ready;
	opcodeT insnOp;
	logic [IMM_W-1:0] insnImm;
	logic [NUM_CORES*IMM_W-1:0] initValue;
	logic [NUM_CORES*REG_W-1:0] peerR0;		// All R0s, core 0 lowest

	apbTaskLoader i_loader (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.taskAddr(taskAddr),
		.busy(busy),
		.done(doneIrq),
		.taskDone(taskDone),
		.peerR0(peerR0),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.go(go),
		.taskWord(taskWord)
	);

	taskScheduler i_scheduler (
		.clk(clk),
		.reset(reset),
		.go(go),
		.taskWord(taskWord),
		.ready(ready),
		.taskAddr(taskAddr),
		.start(start),
		.insnOp(insnOp),
		.insnImm(insnImm),
		.initR0(initR0),
		.initValue(initValue),
		.busy(busy),
		.done(doneIrq),
		.taskDone(taskDone)
	);

	for (genvar i = 0; i < NUM_CORES; i++) begin : gCore
		arrayCore i_core (
			.clk(clk),
			.reset(reset),
			.start(start[i]),
			.insnOp(insnOp),
			.insnImm(insnImm),
			.initR0(initR0[i]),
			.initValue(initValue[i*IMM_W +: IMM_W]),
			.peerR0(peerR0),
			.r0(peerR0[i*REG_W +: REG_W]),
			.ready(ready[i])
		);
	end
endmodule

// File: test/tbApbTasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// Setup and access phases change on falling edges, sampled on the rising edge
task automatic apbXfer(input logic write, input logic [APB_AW-1:0] addr,
	input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata,
	output logic err, output int waits);
	@(negedge clk);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = write;
	paddr = addr;
	pwdata = wdata;
	@(negedge clk);
	penable = 1'b1;
	waits = 0;
	@(posedge clk);
	while (!pready) begin
		waits++;
		@(posedge clk);
	end
	err = pslverr;
	rdata = prdata;
	@(negedge clk);
	psel = 1'b0;
	penable = 1'b0;
endtask

task automatic apbWrite(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
	logic [APB_DW-1:0] rdIgnored;
	logic err;
	int waits;
	apbXfer(1'b1, addr, data, rdIgnored, err, waits);
	checkFlag(!err, $sformatf("write to address %h got a slave error", addr));
endtask

task automatic apbRead(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
	logic err;
	int waits;
	apbXfer(1'b0, addr, '0, data, err, waits);
	checkFlag(!err, $sformatf("read of address %h got a slave error", addr));
endtask

// Control frame, also applies the R0 init to the model
task automatic addCtrl(input logic [MASK_W-1:0] active, input logic [MASK_W-1:0] r0Mask,
	input fenceT fence, input int frames, input logic [31:0] init);
	prog.push_back(TASK_WORD_W'(active) | (TASK_WORD_W'(r0Mask) << R0M_LO)
		| (TASK_WORD_W'(fence) << FENCE_LO) | (TASK_WORD_W'(frames) << FCNT_LO)
		| (TASK_WORD_W'(init) << INIT_LO));
	curActive = active;
	for (int c = 0; c < NUM_CORES; c++) begin
		if (r0Mask[c])
			model[c] = REG_W'(init[c*INIT_W +: INIT_W]);
	end
endtask

// Instruction frame; every active core reads the R0 values from before the frame
task automatic addInsn(input opcodeT op, input logic [IMM_W-1:0] imm);
	logic [REG_W-1:0] old [NUM_CORES];
	logic [REG_W-1:0] ext;
	prog.push_back(TASK_WORD_W'(op) | (TASK_WORD_W'(imm) << IMM_LO));
	old = model;
	ext = REG_W'(imm);
	for (int c = 0; c < NUM_CORES; c++) begin
		if (curActive[c]) begin
			case (op)
				OP_ADDI: model[c] = old[c] + ext;
				OP_SUBI: model[c] = old[c] - ext;
				OP_XORI: model[c] = old[c] ^ ext;
				OP_SHLI: model[c] = old[c] << imm[3:0];
				OP_MULI: model[c] = old[c] * ext;	// Low 16 bits
				OP_ADDC: model[c] = old[c] + old[imm[1:0]];
				default: model[c] = old[c];
			endcase
		end
	end
endtask

task automatic endProgram();
	prog.push_back('0);					// Empty active mask
endtask

task automatic loadProgram();
	for (int i = 0; i < prog.size(); i++) begin
		apbWrite(APB_AW'(i*8), prog[i][APB_DW-1:0]);
		apbWrite(APB_AW'(i*8 + 4), APB_DW'(prog[i][TASK_WORD_W-1:APB_DW]));
	end
	prog.delete();
endtask

task automatic waitDone();
	@(negedge clk);
	checkFlag(!doneIrq, "done did not clear after go");
	while (!doneIrq)
		@(negedge clk);
endtask

task automatic runProgram();
	loadProgram();
	apbWrite(ADDR_CONTROL, 32'd1);
	waitDone();
endtask

`endif

// File: test/taskArrayTb.sv
`timescale 1ns/10ps

module taskArrayTb
	import schedPkg::*;
	import corePkg::*;
();
	localparam int MAX_CYCLES = 6000;		// Six tests of up to 16 frames, x4 margin

	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic doneIrq;

	logic [TASK_WORD_W-1:0] prog [$];		// Program being built
	logic [REG_W-1:0] model [NUM_CORES];		// Expected R0 per core
	logic [NUM_CORES-1:0] curActive;
	logic [6:0] lfsr;
	string testName;
	int errors;
	int errStart;
	int passCount;
	int cycles;

	`include "tbApbTasks.svh"

	taskArray i_taskArray (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.doneIrq(doneIrq)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	// x^7 + x^6 + 1, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[5:0], lfsr[6] ^ lfsr[5]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
			errors++;
		end
	endtask

	task automatic checkFlag(input logic ok, input string what);
		assert (ok) else begin
			$display("ERROR in %s: %s", testName, what);
			errors++;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		errStart = errors;
	endtask

	task automatic finishTest();
		if (errors == errStart) begin
			$display("%s: pass", testName);
			passCount++;
		end else begin
			$display("%s: fail", testName);
		end
	endtask

	task automatic checkR0All();
		logic [APB_DW-1:0] data;
		for (int c = 0; c < NUM_CORES; c++) begin
			apbRead(ADDR_R0_BASE + APB_AW'(c*4), data);
			checkValue($sformatf("core %0d R0", c), 32'(model[c]), data);
		end
	endtask

	task automatic checkStatus(input int count);
		logic [APB_DW-1:0] data;
		apbRead(ADDR_STATUS, data);
		checkValue("task count", count, 32'(data[15:8]));
		checkValue("done/busy", 32'd2, 32'(data[1:0]));
	endtask

	task automatic testBasic();
		startTest("basic");
		addCtrl(4'b1111, 4'b1111, FENCE_NONE, 3, 32'h0403_0201);
		addInsn(OP_ADDI, 8'h10);
		addInsn(OP_XORI, 8'h5A);
		addInsn(OP_SHLI, 8'd3);
		endProgram();
		runProgram();
		checkR0All();
		checkStatus(1);
		finishTest();
	endtask

	task automatic testMultiply();
		startTest("multiply");
		addCtrl(4'b0101, 4'b0101, FENCE_NONE, 3, 32'h0009_0006);
		addInsn(OP_MULI, 8'd7);
		addInsn(OP_ADDI, 8'd3);
		addInsn(OP_MULI, 8'd200);
		addCtrl(4'b1010, 4'b1010, FENCE_NONE, 3, 32'h0500_0400);
		addInsn(OP_SUBI, 8'd1);
		addInsn(OP_MULI, 8'd250);
		addInsn(OP_XORI, 8'hFF);
		endProgram();
		runProgram();
		checkR0All();
		finishTest();
	endtask

	task automatic testFences();
		startTest("fences");
		addCtrl(4'b0001, 4'b0001, FENCE_NONE, 2, 32'h0000_0003);
		addInsn(OP_MULI, 8'd5);
		addInsn(OP_MULI, 8'd7);
		addCtrl(4'b0010, 4'b0010, FENCE_ACQ, 1, 32'h0000_0100);	// Core 1 reads core 0
		addInsn(OP_ADDC, 8'd0);
		addCtrl(4'b0001, 4'b0000, FENCE_REL, 1, 32'h0);
		addInsn(OP_MULI, 8'd3);
		addCtrl(4'b0100, 4'b0100, FENCE_NONE, 1, 32'h0002_0000);	// Held by the release
		addInsn(OP_ADDC, 8'd0);
		endProgram();
		runProgram();
		checkR0All();
		finishTest();
	endtask

	task automatic testNoFence();
		startTest("noFence");
		addCtrl(4'b0011, 4'b0011, FENCE_NONE, 2, 32'h0000_0807);
		addInsn(OP_MULI, 8'd11);
		addInsn(OP_ADDI, 8'd1);
		addCtrl(4'b1100, 4'b1100, FENCE_NONE, 3, 32'h2010_0000);
		addInsn(OP_XORI, 8'h3C);
		addInsn(OP_SHLI, 8'd2);
		addInsn(OP_SUBI, 8'd9);
		addCtrl(4'b0001, 4'b0000, FENCE_NONE, 1, 32'h0);
		addInsn(OP_ADDI, 8'd100);
		endProgram();
		runProgram();
		checkR0All();
		checkStatus(3);
		finishTest();
	endtask

	task automatic testBusErrors();
		logic [APB_DW-1:0] data;
		logic err;
		int waits;
		startTest("busErrors");
		addCtrl(4'b0001, 4'b0001, FENCE_NONE, 4, 32'h0000_0002);
		repeat (4) addInsn(OP_MULI, 8'd3);
		endProgram();
		loadProgram();
		apbWrite(ADDR_CONTROL, 32'd1);
		apbXfer(1'b1, 12'h000, 32'h0, data, err, waits);	// Scheduler still running
		checkFlag(err, "task memory write while busy gave no slave error");
		waitDone();
		apbXfer(1'b0, 12'h008, 32'h0, data, err, waits);
		checkFlag(err, "task memory read gave no slave error");
		apbXfer(1'b0, ADDR_R0_BASE, 32'h0, data, err, waits);
		checkFlag(!err && waits == 1, "R0 read did not take exactly one wait state");
		checkValue("core 0 R0", 32'(model[0]), data);
		finishTest();
	endtask

	task automatic testRandom();
		logic [MASK_W-1:0] active;
		logic [MASK_W-1:0] r0Mask;
		logic [31:0] init;
		logic [2:0] op;
		int frames;
		startTest("randomPrograms");
		for (int p = 0; p < 3; p++) begin
			for (int t = 0; t < 3; t++) begin
				active = MASK_W'(randBits(4));
				if (active == '0)
					active = 4'b0001;
				r0Mask = MASK_W'(randBits(4));
				init = randBits(32);
				frames = 1 + int'(randBits(2));
				addCtrl(active, r0Mask, FENCE_ACQ, frames, init);
				for (int f = 0; f < frames; f++) begin
					op = 3'(randBits(3));
					if (op == 3'd7)
						op = 3'd0;		// No opcode 7
					addInsn(opcodeT'(op), IMM_W'(randBits(8)));
				end
			end
			endProgram();
			runProgram();
			checkR0All();
		end
		finishTest();
	endtask

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr = 7'd63;
		curActive = '0;
		errors = 0;
		errStart = 0;
		passCount = 0;
		cycles = 0;
		foreach (model[c])
			model[c] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		testBasic();
		testMultiply();
		testFences();
		testNoFence();
		testBusErrors();
		testRandom();

		$display("%0d of 6 tests passed, %0d errors", passCount, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end
endmodule

// File: taskArray.f
+incdir+test
verilog/schedPkg.sv
verilog/corePkg.sv
verilog/apbTaskLoader.sv
verilog/taskScheduler.sv
verilog/arrayCore.sv
verilog/taskArray.sv
test/taskArrayTb.sv

// File: Makefile
TOP = taskArrayTb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f taskArray.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f taskArray.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
